//--- flist.f
logic/irda_pkg.sv
logic/irda_tx_fifo.sv
logic/irda_data_ctrl.sv
logic/irda_mir_encoder.sv
logic/irda_fir_encoder.sv
logic/irda_tx_combine.sv
logic/irda_tx_top.sv
sim/irda_tx_tb.sv

//--- logic/irda_data_ctrl.sv
`timescale 1ns/10ps

module irda_data_ctrl (
	input  logic                  clk,
	input  logic                  wb_rst_i,
	input  logic                  restart_i,
	input  irda_pkg::irda_mode_t  mode_i,
	input  logic                  next_data_mir_i,
	input  logic                  next_data_fir_i,
	input  irda_pkg::irda_word_t  fifo_dat_i,
	input  irda_pkg::irda_count_t fifo_count_i,
	output logic                  fifo_remove_o,
	output logic                  data_available_o,
	output logic                  data_o
);
	import irda_pkg::*;

	irda_word_t   sr;	// word being sent
	irda_bitptr_t sr_p;	// position of the current bit in sr
	logic         fifo_empty;
	logic         step;
	logic         last_bit;
	logic         load;

	assign fifo_empty = (fifo_count_i == '0);

	// only the encoder of the active mode may move the pointer
	assign step = ((mode_i == IRDA_MODE_MIR) && next_data_mir_i) ||
	              ((mode_i == IRDA_MODE_FIR) && next_data_fir_i);

	assign last_bit = (sr_p == '1);

	// fetch when empty handed, or right after bit 31 so words follow without a gap.
	// Nothing is fetched while the line is off, so queued words keep their credits.
	assign load = !restart_i && !fifo_empty && (mode_i != IRDA_MODE_OFF) &&
	              (!data_available_o || (step && last_bit));

	assign data_o = sr[sr_p];	// lsb first

	always_ff @(posedge clk) begin
		if (load)
			sr <= fifo_dat_i;
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			sr_p             <= '0;
			fifo_remove_o    <= 1'b0;
			data_available_o <= 1'b0;
		end else if (restart_i) begin
			// drop whatever is left of the current word
			sr_p             <= '0;
			fifo_remove_o    <= 1'b0;
			data_available_o <= 1'b0;
		end else if (load) begin
			sr_p             <= '0;
			fifo_remove_o    <= 1'b1;	// head word now lives in sr
			data_available_o <= 1'b1;
		end else if (step && data_available_o) begin
			fifo_remove_o <= 1'b0;
			if (last_bit) begin
				sr_p             <= '0;	// word done and nothing queued
				data_available_o <= 1'b0;
			end else begin
				sr_p <= sr_p + 1'b1;
			end
		end else begin
			fifo_remove_o <= 1'b0;	// remove is a single cycle pulse
		end
	end

endmodule

//--- logic/irda_fir_encoder.sv
`timescale 1ns/10ps

module irda_fir_encoder #(
	parameter int DIV = irda_pkg::IRDA_FIR_DIV_DEF
) (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic data_available_i,
	input  logic data_i,
	output logic next_data_o,
	output logic line_o,
	output logic busy_o
);

	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	typedef enum logic [1:0] {
		S_IDLE,
		S_BIT0,	// take first bit of the pair
		S_BIT1,	// take second bit of the pair
		S_SEND	// pair waits while the current symbol goes out
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] div_cnt;	// clocks within a chip
	logic [1:0]       chip_idx;	// chip within the symbol
	logic             slot_end;
	logic             bit0;
	logic [1:0]       pair;	// value for the next symbol
	logic             pair_valid;
	logic [1:0]       sym;	// value of the symbol on the line
	logic             sym_valid;

	assign slot_end = (chip_idx == 2'd3) && (div_cnt == CNT_W'(DIV - 1));

	// requests fall on the first two cycles of a symbol slot
	assign next_data_o = ((state == S_BIT0) || (state == S_BIT1)) && data_available_i;

	assign line_o = sym_valid && (chip_idx == sym);	// 4ppm, one chip high
	assign busy_o = sym_valid;

	// free running chip timer
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			div_cnt  <= '0;
			chip_idx <= '0;
		end else if (div_cnt == CNT_W'(DIV - 1)) begin
			div_cnt  <= '0;
			chip_idx <= chip_idx + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state      <= S_IDLE;
			pair_valid <= 1'b0;
			sym_valid  <= 1'b0;
		end else begin
			if (slot_end) begin
				sym_valid  <= pair_valid;
				pair_valid <= 1'b0;
			end

			case (state)
				S_IDLE:
					if (slot_end && data_available_i)
						state <= S_BIT0;
				S_BIT0:
					state <= data_available_i ? S_BIT1 : S_IDLE;
				S_BIT1: begin
					pair_valid <= 1'b1;	// short pair still goes out
					state      <= data_available_i ? S_SEND : S_IDLE;
				end
				default:
					if (slot_end)
						state <= data_available_i ? S_BIT0 : S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_BIT0)
			bit0 <= data_i;
		if (state == S_BIT1)
			pair <= {data_available_i & data_i, bit0};	// first bit is the lsb
		if (slot_end)
			sym <= pair;
	end

endmodule

//--- logic/irda_mir_encoder.sv
`timescale 1ns/10ps

module irda_mir_encoder #(
	parameter int DIV = irda_pkg::IRDA_MIR_DIV_DEF
) (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic data_available_i,
	input  logic data_i,
	output logic next_data_o,
	output logic line_o,
	output logic busy_o
);

	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] div_cnt;	// clocks within the bit period
	logic [2:0]       ones;	// consecutive ones on the line
	logic             tick;
	logic             stuff;

	assign tick  = (div_cnt == CNT_W'(DIV - 1));
	assign stuff = (ones == 3'd5);	// hdlc rule, zero after five ones

	// a data bit is taken on the tick that puts it on the line
	assign next_data_o = tick && !stuff && data_available_i;

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			line_o <= 1'b1;	// line idles high
			busy_o <= 1'b0;
			ones   <= '0;
		end else if (tick) begin
			if (stuff) begin
				line_o <= 1'b0;	// stuffed bit, still part of the frame
				ones   <= '0;
			end else if (data_available_i) begin
				line_o <= data_i;
				busy_o <= 1'b1;
				ones   <= data_i ? ones + 1'b1 : '0;
			end else begin
				// idle ones are not data and never get stuffed
				line_o <= 1'b1;
				busy_o <= 1'b0;
				ones   <= '0;
			end
		end
	end

endmodule

//--- logic/irda_pkg.sv
package irda_pkg;

	// widths with a meaning of their own
	localparam int IRDA_WORD_W   = 32;
	localparam int IRDA_COUNT_W  = 5;	// holds 0..depth for the default depth
	localparam int IRDA_BITPTR_W = 5;

	// one transmit data word
	typedef logic [IRDA_WORD_W-1:0] irda_word_t;

	// fifo fill level
	typedef logic [IRDA_COUNT_W-1:0] irda_count_t;

	// bit position inside a word
	typedef logic [IRDA_BITPTR_W-1:0] irda_bitptr_t;

	// line modes
	typedef enum logic [1:0] {
		IRDA_MODE_OFF = 2'd0,
		IRDA_MODE_MIR = 2'd1,
		IRDA_MODE_FIR = 2'd2
	} irda_mode_t;

	// defaults for the top level parameters
	localparam int IRDA_FIFO_DEPTH_DEF = 16;	// words
	localparam int IRDA_MIR_DIV_DEF    = 8;	// clocks per mir bit
	localparam int IRDA_FIR_DIV_DEF    = 2;	// clocks per fir chip

endpackage

//--- logic/irda_tx_combine.sv
`timescale 1ns/10ps

module irda_tx_combine (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  irda_pkg::irda_mode_t mode_i,
	input  logic                 mir_line_i,
	input  logic                 mir_busy_i,
	input  logic                 fir_line_i,
	input  logic                 fir_busy_i,
	output logic                 tx_o,
	output logic                 tx_active_o
);
	import irda_pkg::*;

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			tx_o        <= 1'b0;
			tx_active_o <= 1'b0;
		end else begin
			case (mode_i)
				IRDA_MODE_MIR: begin
					tx_o        <= mir_line_i;
					tx_active_o <= mir_busy_i;
				end
				IRDA_MODE_FIR: begin
					tx_o        <= fir_line_i;
					tx_active_o <= fir_busy_i;
				end
				default: begin
					tx_o        <= 1'b0;	// transmitter off
					tx_active_o <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- logic/irda_tx_fifo.sv
`timescale 1ns/10ps

module irda_tx_fifo #(
	parameter int DEPTH = irda_pkg::IRDA_FIFO_DEPTH_DEF
) (
	input  logic                  clk,
	input  logic                  wb_rst_i,
	input  logic                  push_i,
	input  irda_pkg::irda_word_t  push_dat_i,
	input  logic                  remove_i,
	output irda_pkg::irda_word_t  head_dat_o,
	output irda_pkg::irda_count_t count_o,
	output logic                  credit_o
);
	import irda_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	irda_word_t       mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	irda_count_t      count;
	logic             do_push;
	logic             do_pop;

	// pointer step with wrap at depth
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// host credits keep a push off a full fifo, the guard is only a safety net
	assign do_push = push_i && (count != irda_count_t'(DEPTH));
	assign do_pop  = remove_i && (count != '0);

	assign head_dat_o = mem[rd_ptr];	// head word is always visible
	assign count_o    = count;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_dat_i;
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);

			// push and pop together leave the level alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;

			credit_o <= do_pop;	// one credit back per word taken
		end
	end

endmodule

//--- logic/irda_tx_top.sv
`timescale 1ns/10ps

module irda_tx_top #(
	parameter int FIFO_DEPTH = irda_pkg::IRDA_FIFO_DEPTH_DEF,
	parameter int MIR_DIV    = irda_pkg::IRDA_MIR_DIV_DEF,
	parameter int FIR_DIV    = irda_pkg::IRDA_FIR_DIV_DEF
) (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  irda_pkg::irda_mode_t mode_i,
	input  logic                 restart_i,
	input  logic                 host_wr_i,
	input  irda_pkg::irda_word_t host_dat_i,
	output logic                 host_credit_o,
	output logic                 tx_o,
	output logic                 tx_active_o
);
	import irda_pkg::*;

	irda_word_t  fifo_dat;
	irda_count_t fifo_count;
	logic        fifo_remove;
	logic        data_bit;
	logic        data_available;
	logic        next_data_mir;
	logic        next_data_fir;
	logic        mir_line;
	logic        mir_busy;
	logic        fir_line;
	logic        fir_busy;

	irda_tx_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.push_i     (host_wr_i),
		.push_dat_i (host_dat_i),
		.remove_i   (fifo_remove),
		.head_dat_o (fifo_dat),
		.count_o    (fifo_count),
		.credit_o   (host_credit_o)
	);

	irda_data_ctrl u_data_ctrl (
		.clk              (clk),
		.wb_rst_i         (wb_rst_i),
		.restart_i        (restart_i),
		.mode_i           (mode_i),
		.next_data_mir_i  (next_data_mir),
		.next_data_fir_i  (next_data_fir),
		.fifo_dat_i       (fifo_dat),
		.fifo_count_i     (fifo_count),
		.fifo_remove_o    (fifo_remove),
		.data_available_o (data_available),
		.data_o           (data_bit)
	);

	irda_mir_encoder #(
		.DIV(MIR_DIV)
	) u_mir (
		.clk              (clk),
		.wb_rst_i         (wb_rst_i),
		.data_available_i (data_available),
		.data_i           (data_bit),
		.next_data_o      (next_data_mir),
		.line_o           (mir_line),
		.busy_o           (mir_busy)
	);

	irda_fir_encoder #(
		.DIV(FIR_DIV)
	) u_fir (
		.clk              (clk),
		.wb_rst_i         (wb_rst_i),
		.data_available_i (data_available),
		.data_i           (data_bit),
		.next_data_o      (next_data_fir),
		.line_o           (fir_line),
		.busy_o           (fir_busy)
	);

	irda_tx_combine u_combine (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.mode_i      (mode_i),
		.mir_line_i  (mir_line),
		.mir_busy_i  (mir_busy),
		.fir_line_i  (fir_line),
		.fir_busy_i  (fir_busy),
		.tx_o        (tx_o),
		.tx_active_o (tx_active_o)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module irda_tx_tb -f flist.f -o irda_tx_sim \
	&& ./obj_dir/irda_tx_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- sim/irda_tx_tb.sv
`timescale 1ns/10ps

module irda_tx_tb;
	import irda_pkg::*;

	localparam int FIFO_DEPTH   = IRDA_FIFO_DEPTH_DEF;
	localparam int MIR_DIV      = IRDA_MIR_DIV_DEF;
	localparam int FIR_DIV      = IRDA_FIR_DIV_DEF;
	localparam int MAX_WORDS    = 32;
	localparam int N_WORDS      = 26;	// mir burst, restart, off and fir words
	localparam int MIR_WORD_CYC = (32 * MIR_DIV * 6) / 5 + MIR_DIV;	// one stuffed bit per five
	localparam int CYCLE_LIMIT  = N_WORDS * MIR_WORD_CYC * 2;

	logic       clk;
	logic       wb_rst_i;
	irda_mode_t mode_i;
	logic       restart_i;
	logic       host_wr_i;
	irda_word_t host_dat_i;
	logic       host_credit_o;
	logic       tx_o;
	logic       tx_active_o;

	irda_word_t  exp_word [MAX_WORDS];	// words in write order
	int          words_written;
	int          restarts;
	logic [31:0] rng;
	int          chk_errors;

	int          credits_seen;
	int          rd_bit;	// position in the expected bit stream
	int          restarts_seen;
	int          mir_phase;
	int          mir_ones;
	int          fir_phase;
	logic [3:0]  fir_chips;
	irda_mode_t  mode_q;
	int          mon_errors;
	int          cycles;

	irda_tx_top uut (
		.clk           (clk),
		.wb_rst_i      (wb_rst_i),
		.mode_i        (mode_i),
		.restart_i     (restart_i),
		.host_wr_i     (host_wr_i),
		.host_dat_i    (host_dat_i),
		.host_credit_o (host_credit_o),
		.tx_o          (tx_o),
		.tx_active_o   (tx_active_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int credits_held();
		return FIFO_DEPTH - words_written + credits_seen;
	endfunction

	task automatic expect_bit(input string name, input logic act, input logic exp);
		assert (act === exp) else begin
			$display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
			mon_errors++;
		end
	endtask

	task automatic expect_count(input string name, input int act, input int exp);
		assert (act == exp) else begin
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			chk_errors++;
		end
	endtask

	// compare one decoded data bit with the written words in lsb first order
	task automatic take_bit(input logic b);
		logic [4:0] word_sel;
		logic [4:0] bit_sel;
		assert (rd_bit < words_written * 32) else begin
			$display("a data bit was decoded at %0t with no written word left", $time);
			mon_errors++;
		end
		if (rd_bit < words_written * 32) begin
			word_sel = 5'(rd_bit / 32);
			bit_sel  = 5'(rd_bit % 32);
			expect_bit("tx_o data bit", b, exp_word[word_sel][bit_sel]);
			rd_bit++;
		end
	endtask

	task automatic mir_sample(input logic b);
		if (mir_ones == 5) begin
			expect_bit("tx_o stuffed bit", b, 1'b0);	// a sixth one is an error too
			mir_ones = 0;
		end else begin
			mir_ones = b ? mir_ones + 1 : 0;
			take_bit(b);
		end
	endtask

	task automatic fir_symbol();
		logic [1:0] sym;
		logic       one_hot;
		one_hot = 1'b1;
		sym     = 2'd0;
		case (fir_chips)
			4'b0001: sym = 2'd0;
			4'b0010: sym = 2'd1;
			4'b0100: sym = 2'd2;
			4'b1000: sym = 2'd3;
			default: one_hot = 1'b0;
		endcase
		assert (one_hot) else begin
			$display("fir symbol at %0t does not have exactly one high chip: %b",
				$time, fir_chips);
			mon_errors++;
		end
		if (one_hot) begin
			take_bit(sym[0]);
			take_bit(sym[1]);
		end
	endtask

	// line decoders and credit tracking run on the falling edge
	initial begin
		credits_seen  = 0;
		rd_bit        = 0;
		restarts_seen = 0;
		mir_phase     = 0;
		mir_ones      = 0;
		fir_phase     = 0;
		fir_chips     = '0;
		mode_q        = IRDA_MODE_OFF;
		mon_errors    = 0;
		forever begin
			@(negedge clk);
			if (wb_rst_i || (mode_i == IRDA_MODE_OFF && mode_q == IRDA_MODE_OFF)) begin
				expect_bit("tx_o", tx_o, 1'b0);
				expect_bit("tx_active_o", tx_active_o, 1'b0);
				expect_bit("host_credit_o", host_credit_o, 1'b0);
			end
			if (host_credit_o === 1'b1)
				credits_seen++;
			assert (credits_held() >= 0 && credits_held() <= FIFO_DEPTH) else begin
				$display("host credit count left its range at %0t: %0d", $time, credits_held());
				mon_errors++;
			end
			if (restarts != restarts_seen) begin
				restarts_seen = restarts;
				if (rd_bit % 32 != 0)
					rd_bit = (rd_bit / 32 + 1) * 32;	// rest of the word never goes out
			end
			if (tx_active_o !== 1'b1) begin
				assert (fir_phase == 0) else begin
					$display("fir symbol cut short at %0t", $time);
					mon_errors++;
				end
				mir_phase = 0;
				mir_ones  = 0;
				fir_phase = 0;
			end else if (mode_i == IRDA_MODE_MIR) begin
				if (mir_phase == 0)
					mir_sample(tx_o);
				mir_phase = (mir_phase + 1) % MIR_DIV;
			end else if (mode_i == IRDA_MODE_FIR) begin
				if (fir_phase % FIR_DIV == 0)
					fir_chips = {tx_o, fir_chips[3:1]};	// chip 0 ends up in bit 0
				if (fir_phase == 4 * FIR_DIV - 1)
					fir_symbol();
				fir_phase = (fir_phase + 1) % (4 * FIR_DIV);
			end
			mode_q = mode_i;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, traffic still pending after %0d cycles", cycles);
		$display("TESTS FAILED");
		$finish;
	end

	// write one word once a credit is held, then stay idle for gap cycles
	task automatic write_word(input irda_word_t w, input int gap);
		while (credits_held() == 0) begin
			@(posedge clk);
			#1;
		end
		host_wr_i  = 1'b1;
		host_dat_i = w;
		exp_word[5'(words_written)] = w;
		words_written++;
		@(posedge clk);
		#1;
		host_wr_i = 1'b0;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic write_burst(input int n_tight, input int n_gapped);
		irda_word_t w;
		for (int i = 0; i < n_tight + n_gapped; i++) begin
			rng = lcg_next(rng);
			w   = rng;
			rng = lcg_next(rng);
			write_word(w, (i < n_tight) ? 0 : int'(rng[15:0]) % MIR_WORD_CYC);
		end
	endtask

	task automatic wait_drain();
		int quiet;
		quiet = 0;
		while (quiet < 4 * MIR_DIV) begin
			@(posedge clk);
			#1;
			if (rd_bit == words_written * 32 && tx_active_o == 1'b0)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic check_credits();
		expect_count("host_credit_o pulses", credits_seen, words_written);
		expect_count("credits held", credits_held(), FIFO_DEPTH);
	endtask

	// pulse restart just after a data sample and well inside a word
	task automatic restart_mid_word();
		while (!(tx_active_o && mir_phase == 1 && rd_bit % 32 >= 6 && rd_bit % 32 <= 25)) begin
			@(posedge clk);
			#1;
		end
		restart_i = 1'b1;
		restarts++;
		@(posedge clk);
		#1;
		restart_i = 1'b0;
	endtask

	initial begin
		int credits_before;
		wb_rst_i      = 1'b1;
		mode_i        = IRDA_MODE_OFF;
		restart_i     = 1'b0;
		host_wr_i     = 1'b0;
		host_dat_i    = '0;
		words_written = 0;
		restarts      = 0;
		rng           = 32'hb07a_9152;
		chk_errors    = 0;
		repeat (4) @(posedge clk);
		#1;
		wb_rst_i = 1'b0;
		repeat (2) @(posedge clk);	// line stays quiet right after reset
		#1;

		mode_i = IRDA_MODE_MIR;
		write_word(32'hffff_ffff, 0);	// stuffing after every fifth one
		write_burst(5, 4);
		wait_drain();
		check_credits();

		write_burst(3, 0);
		restart_mid_word();
		wait_drain();
		check_credits();

		mode_i         = IRDA_MODE_OFF;
		credits_before = credits_seen;
		write_burst(3, 0);
		repeat (2 * MIR_WORD_CYC) @(posedge clk);
		#1;
		expect_count("host_credit_o pulses while off", credits_seen, credits_before);
		mode_i = IRDA_MODE_MIR;	// queued words go out now
		wait_drain();
		check_credits();

		mode_i = IRDA_MODE_FIR;
		write_burst(6, 4);
		wait_drain();
		check_credits();

		$display("run ended after %0d cycles: %0d line errors, %0d end of phase errors",
			cycles, mon_errors, chk_errors);
		if (mon_errors + chk_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
